// File: hdl/sc_cfg.svh
// Core configuration macros
`ifndef SC_CFG_SVH
`define SC_CFG_SVH

// Architectural register count, r0 hardwired to zero
`define SC_NREGS 16

// Data and address width
`define SC_XLEN 32

// First fetch address after reset
`define SC_RESET_PC 32'h0000_0000

// Byte step between sequential instructions
`define SC_PC_STEP 32'd4

`endif

// File: hdl/isa_pkg.sv
// Instruction set definitions
`default_nettype none

package isa_pkg;

    // Top nibble of every instruction word
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SLT  = 4'h5,
        OP_ADDI = 4'h6,
        OP_LW   = 4'h7,
        OP_SW   = 4'h8,
        OP_BEQ  = 4'h9,
        OP_HALT = 4'hE,
        OP_NOP  = 4'hF
    } opcode_t;

    // Fixed 32-bit format, imm sign-extended by decode
    typedef struct packed {
        opcode_t     opcode;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [15:0] imm;
    } instr_t;

    // ALU functions after decode
    // ALU_EQ is the branch compare and writes nothing back
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_EQ
    } alu_op_t;

    // Target functional unit
    typedef enum logic [1:0] {
        FU_NONE,
        FU_ALU,
        FU_LS
    } fu_sel_t;

endpackage

`default_nettype wire

// File: hdl/pipeline_pkg.sv
// Pipeline latch and result types
`default_nettype none
`include "sc_cfg.svh"

package pipeline_pkg;
    import isa_pkg::*;

    // Fetch/dispatch latch
    typedef struct packed {
        logic                valid;
        logic [`SC_XLEN-1:0] pc;
        instr_t              instr;
    } fd_t;

    // Issue/execute latch, one copy seen by both units
    // rdat2 already holds the immediate for ADDI
    typedef struct packed {
        logic                valid;
        fu_sel_t             fu;
        alu_op_t             alu_op;
        logic [3:0]          rd;
        logic [`SC_XLEN-1:0] rdat1;
        logic [`SC_XLEN-1:0] rdat2;
        logic [`SC_XLEN-1:0] imm;
        logic [`SC_XLEN-1:0] pc;
        logic                is_store;
    } ie_t;

    // Held load/store request inside the LS unit
    typedef struct packed {
        logic                is_store;
        logic [3:0]          rd;
        logic [`SC_XLEN-1:0] addr;
        logic [`SC_XLEN-1:0] data;
    } ls_req_t;

    // Register writeback from one unit
    typedef struct packed {
        logic                valid;
        logic [3:0]          rd;
        logic [`SC_XLEN-1:0] data;
    } wb_t;

    // Taken branch target
    typedef struct packed {
        logic                valid;
        logic [`SC_XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: hdl/fetch.sv
// Instruction fetch stage
`default_nettype none
`include "sc_cfg.svh"

module fetch
    import pipeline_pkg::*;
(
    input  logic                CLK,
    input  logic                nrst,
    input  logic                ihit,
    input  logic [`SC_XLEN-1:0] imemload,
    input  logic                stall,
    input  redirect_t           redirect,
    output logic [`SC_XLEN-1:0] imemaddr,
    output fd_t                 fd
);

    logic [`SC_XLEN-1:0] pc;

    // Memory always sees the current PC
    assign imemaddr = pc;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc <= `SC_RESET_PC;
            fd <= '0;
        end else if (redirect.valid) begin
            // Taken branch, drop the wrong-path word
            pc       <= redirect.target;
            fd.valid <= 1'b0;
        end else if (!stall) begin
            // fd was consumed or empty, refill when memory answers
            fd.valid <= ihit;
            if (ihit) begin
                pc       <= pc + `SC_PC_STEP;
                fd.pc    <= pc;
                fd.instr <= imemload;
            end
        end
        // Stalled, fd and PC hold
    end

endmodule

`default_nettype wire

// File: hdl/scoreboard.sv
// Decode, hazard check and issue
`default_nettype none
`include "sc_cfg.svh"

module scoreboard
    import isa_pkg::*;
    import pipeline_pkg::*;
(
    input  logic                CLK,
    input  logic                nrst,
    input  fd_t                 fd,
    output logic [3:0]          rsel1,
    output logic [3:0]          rsel2,
    input  logic [`SC_XLEN-1:0] rdat1,
    input  logic [`SC_XLEN-1:0] rdat2,
    input  wb_t                 alu_wb,
    input  wb_t                 ls_wb,
    input  logic                ls_busy,
    input  redirect_t           redirect,
    output logic                stall,
    output ie_t                 ie,
    output logic                halt
);

    logic [`SC_NREGS-1:0] pending;
    logic [`SC_NREGS-1:0] set_mask;
    logic [`SC_NREGS-1:0] clr_mask;
    logic [`SC_NREGS-1:0] busy_regs;
    logic [`SC_XLEN-1:0]  imm_ext;
    fu_sel_t              dec_fu;
    alu_op_t              dec_alu;
    logic                 uses_rs1;
    logic                 uses_rs2;
    logic                 writes_rd;
    logic                 is_halt;
    logic                 branch_in_ie;
    logic                 hazard;
    logic                 issue;
    logic                 halt_cond;

    // Register reads go straight from the fd latch
    assign rsel1   = fd.instr.rs1;
    assign rsel2   = fd.instr.rs2;
    assign imm_ext = {{(`SC_XLEN-16){fd.instr.imm[15]}}, fd.instr.imm};

    // Opcode to unit, ALU function and register usage
    always_comb begin
        dec_fu    = FU_NONE;
        dec_alu   = ALU_ADD;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        writes_rd = 1'b0;
        is_halt   = 1'b0;
        case (fd.instr.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
                dec_fu    = FU_ALU;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                writes_rd = 1'b1;
                case (fd.instr.opcode)
                    OP_SUB:  dec_alu = ALU_SUB;
                    OP_AND:  dec_alu = ALU_AND;
                    OP_OR:   dec_alu = ALU_OR;
                    OP_XOR:  dec_alu = ALU_XOR;
                    OP_SLT:  dec_alu = ALU_SLT;
                    default: dec_alu = ALU_ADD;
                endcase
            end
            OP_ADDI: begin
                dec_fu    = FU_ALU;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_LW: begin
                dec_fu    = FU_LS;
                uses_rs1  = 1'b1;
                writes_rd = 1'b1;
            end
            OP_SW: begin
                dec_fu   = FU_LS;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OP_BEQ: begin
                dec_fu   = FU_ALU;
                dec_alu  = ALU_EQ;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OP_HALT: is_halt = 1'b1;
            // NOP and unknown opcodes retire without a unit
            default: dec_fu = FU_NONE;
        endcase
    end

    // Writebacks this cycle free their register at the edge
    always_comb begin
        clr_mask = '0;
        if (alu_wb.valid) clr_mask[alu_wb.rd] = 1'b1;
        if (ls_wb.valid)  clr_mask[ls_wb.rd]  = 1'b1;
    end

    // Regfile bypass makes a clearing register readable now
    assign busy_regs = pending & ~clr_mask;

    assign branch_in_ie = ie.valid && ie.fu == FU_ALU && ie.alu_op == ALU_EQ;

    assign hazard = (uses_rs1 && busy_regs[fd.instr.rs1])
                 || (uses_rs2 && busy_regs[fd.instr.rs2])
                 || (writes_rd && busy_regs[fd.instr.rd])
                 || (dec_fu == FU_LS && ls_busy)
                 || branch_in_ie
                 || redirect.valid;

    assign issue     = fd.valid && !hazard && !is_halt && !halt;
    assign stall     = halt || (fd.valid && !issue);
    assign halt_cond = fd.valid && is_halt && pending == '0 && !ls_busy && !branch_in_ie;

    // r0 never goes pending
    always_comb begin
        set_mask = '0;
        if (issue && writes_rd && fd.instr.rd != 4'd0) set_mask[fd.instr.rd] = 1'b1;
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pending <= '0;
            ie      <= '0;
            halt    <= 1'b0;
        end else begin
            pending  <= busy_regs | set_mask;
            halt     <= halt || halt_cond;
            ie.valid <= issue && dec_fu != FU_NONE;
            if (issue) begin
                ie.fu       <= dec_fu;
                ie.alu_op   <= dec_alu;
                ie.rd       <= writes_rd ? fd.instr.rd : 4'd0;
                ie.rdat1    <= rdat1;
                ie.rdat2    <= (fd.instr.opcode == OP_ADDI) ? imm_ext : rdat2;
                ie.imm      <= imm_ext;
                ie.pc       <= fd.pc;
                ie.is_store <= fd.instr.opcode == OP_SW;
            end
        end
    end

    // LS unit must take the request and go busy right after issue
    assert property (@(posedge CLK) disable iff (!nrst)
        (issue && dec_fu == FU_LS) |=> ls_busy);

    // A register marked pending twice would meet its second writeback already clear
    assert property (@(posedge CLK) disable iff (!nrst)
        (clr_mask[`SC_NREGS-1:1] & ~pending[`SC_NREGS-1:1]) == '0);

endmodule

`default_nettype wire

// File: hdl/regfile.sv
// Two-read two-write register file
`default_nettype none
`include "sc_cfg.svh"

module regfile
    import pipeline_pkg::*;
(
    input  logic                CLK,
    input  logic                nrst,
    input  logic [3:0]          rsel1,
    input  logic [3:0]          rsel2,
    output logic [`SC_XLEN-1:0] rdat1,
    output logic [`SC_XLEN-1:0] rdat2,
    input  wb_t                 alu_wb,
    input  wb_t                 ls_wb
);

    logic [`SC_XLEN-1:0] regs [`SC_NREGS];

    // Write-through read, a same-cycle write wins over the array
    function automatic logic [`SC_XLEN-1:0] read_port(input logic [3:0] sel);
        if (sel == 4'd0)                       return '0;
        else if (ls_wb.valid && ls_wb.rd == sel)   return ls_wb.data;
        else if (alu_wb.valid && alu_wb.rd == sel) return alu_wb.data;
        else                                   return regs[sel];
    endfunction

    assign rdat1 = read_port(rsel1);
    assign rdat2 = read_port(rsel2);

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            regs <= '{default: '0};
        end else begin
            if (alu_wb.valid && alu_wb.rd != 4'd0) regs[alu_wb.rd] <= alu_wb.data;
            if (ls_wb.valid && ls_wb.rd != 4'd0)   regs[ls_wb.rd]   <= ls_wb.data;
        end
    end

    // Scoreboard keeps the two units on different destinations
    assert property (@(posedge CLK) disable iff (!nrst)
        !(alu_wb.valid && ls_wb.valid && alu_wb.rd == ls_wb.rd && alu_wb.rd != 4'd0));

endmodule

`default_nettype wire

// File: hdl/fu_alu.sv
// Scalar ALU and branch unit
`default_nettype none
`include "sc_cfg.svh"

module fu_alu
    import isa_pkg::*;
    import pipeline_pkg::*;
(
    input  logic      CLK,
    input  logic      nrst,
    input  ie_t       ie,
    output wb_t       alu_wb,
    output redirect_t redirect
);

    logic                take;
    logic [`SC_XLEN-1:0] result;

    // Only valid ALU-bound work is ours
    assign take = ie.valid && ie.fu == FU_ALU;

    always_comb begin
        case (ie.alu_op)
            ALU_SUB: result = ie.rdat1 - ie.rdat2;
            ALU_AND: result = ie.rdat1 & ie.rdat2;
            ALU_OR:  result = ie.rdat1 | ie.rdat2;
            ALU_XOR: result = ie.rdat1 ^ ie.rdat2;
            ALU_SLT: result = {{(`SC_XLEN-1){1'b0}}, $signed(ie.rdat1) < $signed(ie.rdat2)};
            // ADD, ADDI and the unused branch result
            default: result = ie.rdat1 + ie.rdat2;
        endcase
    end

    // Result goes back in the same cycle, written at its closing edge
    assign alu_wb.valid = take && ie.alu_op != ALU_EQ;
    assign alu_wb.rd    = ie.rd;
    assign alu_wb.data  = result;

    // BEQ, target is pc + 4 + imm*4
    assign redirect.valid  = take && ie.alu_op == ALU_EQ && ie.rdat1 == ie.rdat2;
    assign redirect.target = ie.pc + `SC_PC_STEP + {ie.imm[`SC_XLEN-3:0], 2'b00};

    // A taken branch leaves nothing issued behind it
    assert property (@(posedge CLK) disable iff (!nrst)
        redirect.valid |=> !ie.valid);

endmodule

`default_nettype wire

// File: hdl/fu_scalar_ls.sv
// Scalar load/store unit
`default_nettype none
`include "sc_cfg.svh"

module fu_scalar_ls
    import isa_pkg::*;
    import pipeline_pkg::*;
(
    input  logic                CLK,
    input  logic                nrst,
    input  ie_t                 ie,
    input  logic [`SC_XLEN-1:0] dmemload,
    input  logic                dhit,
    output logic [`SC_XLEN-1:0] dmemaddr,
    output logic [`SC_XLEN-1:0] dmemstore,
    output logic                dmemREN,
    output logic                dmemWEN,
    output logic                ls_busy,
    output wb_t                 ls_wb
);

    typedef enum logic {
        LS_IDLE,
        LS_ACCESS
    } ls_state_t;

    ls_state_t state;
    ls_req_t   req;
    logic      accept;

    assign accept = state == LS_IDLE && ie.valid && ie.fu == FU_LS;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            state <= LS_IDLE;
        end else if (accept) begin
            state <= LS_ACCESS;
        end else if (state == LS_ACCESS && dhit) begin
            state <= LS_IDLE;
        end
    end

    // Request payload, captured once and held steady until dhit
    always_ff @(posedge CLK) begin
        if (accept) begin
            req.is_store <= ie.is_store;
            req.rd       <= ie.rd;
            req.addr     <= ie.rdat1 + ie.imm;
            req.data     <= ie.rdat2;
        end
    end

    // Busy from the issue edge, while the request still sits in ie
    assign ls_busy   = accept || state == LS_ACCESS;
    assign dmemaddr  = req.addr;
    assign dmemstore = req.data;
    assign dmemREN   = state == LS_ACCESS && !req.is_store;
    assign dmemWEN   = state == LS_ACCESS && req.is_store;

    // Load data returns on the completing cycle
    assign ls_wb.valid = dmemREN && dhit;
    assign ls_wb.rd    = req.rd;
    assign ls_wb.data  = dmemload;

    // An LS request in ie always finds the unit free, none is dropped
    assert property (@(posedge CLK) disable iff (!nrst)
        (ie.valid && ie.fu == FU_LS) |-> state == LS_IDLE);

endmodule

`default_nettype wire

// File: hdl/sc_datapath.sv
// Scalar core top level
`default_nettype none
`include "sc_cfg.svh"

module sc_datapath
    import pipeline_pkg::*;
(
    input  logic                CLK,
    input  logic                nrst,
    // Instruction memory
    output logic [`SC_XLEN-1:0] imemaddr,
    input  logic [`SC_XLEN-1:0] imemload,
    input  logic                ihit,
    // Data memory
    output logic [`SC_XLEN-1:0] dmemaddr,
    output logic [`SC_XLEN-1:0] dmemstore,
    output logic                dmemREN,
    output logic                dmemWEN,
    input  logic [`SC_XLEN-1:0] dmemload,
    input  logic                dhit,
    output logic                halt
);

    // Stage-to-stage wiring
    fd_t                 fd;
    ie_t                 ie;
    wb_t                 alu_wb;
    wb_t                 ls_wb;
    redirect_t           redirect;
    logic                stall;
    logic                ls_busy;
    logic [3:0]          rsel1;
    logic [3:0]          rsel2;
    logic [`SC_XLEN-1:0] rdat1;
    logic [`SC_XLEN-1:0] rdat2;

    fetch u_fetch (
        .CLK      (CLK),
        .nrst     (nrst),
        .ihit     (ihit),
        .imemload (imemload),
        .stall    (stall),
        .redirect (redirect),
        .imemaddr (imemaddr),
        .fd       (fd)
    );

    scoreboard u_scoreboard (
        .CLK      (CLK),
        .nrst     (nrst),
        .fd       (fd),
        .rsel1    (rsel1),
        .rsel2    (rsel2),
        .rdat1    (rdat1),
        .rdat2    (rdat2),
        .alu_wb   (alu_wb),
        .ls_wb    (ls_wb),
        .ls_busy  (ls_busy),
        .redirect (redirect),
        .stall    (stall),
        .ie       (ie),
        .halt     (halt)
    );

    regfile u_regfile (
        .CLK    (CLK),
        .nrst   (nrst),
        .rsel1  (rsel1),
        .rsel2  (rsel2),
        .rdat1  (rdat1),
        .rdat2  (rdat2),
        .alu_wb (alu_wb),
        .ls_wb  (ls_wb)
    );

    // Both units see the same ie and pick by fu
    fu_alu u_fu_alu (
        .CLK      (CLK),
        .nrst     (nrst),
        .ie       (ie),
        .alu_wb   (alu_wb),
        .redirect (redirect)
    );

    fu_scalar_ls u_fu_scalar_ls (
        .CLK       (CLK),
        .nrst      (nrst),
        .ie        (ie),
        .dmemload  (dmemload),
        .dhit      (dhit),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .ls_busy   (ls_busy),
        .ls_wb     (ls_wb)
    );

endmodule

`default_nettype wire

// File: dv/sc_datapath_tb.sv
// Scalar core testbench
`default_nettype none
`include "sc_cfg.svh"

module sc_datapath_tb
    import isa_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NTESTS     = 4;
    localparam int MAX_STORES = 64;

    logic                CLK;
    logic                nrst;
    logic [`SC_XLEN-1:0] imemaddr;
    logic [`SC_XLEN-1:0] imemload;
    logic                ihit;
    logic [`SC_XLEN-1:0] dmemaddr;
    logic [`SC_XLEN-1:0] dmemstore;
    logic                dmemREN;
    logic                dmemWEN;
    logic [`SC_XLEN-1:0] dmemload;
    logic                dhit;
    logic                halt;

    // Word-addressed memories, 1 KB each
    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    // Stores predicted by the ISA model, in program order
    logic [31:0] exp_addr [MAX_STORES];
    logic [31:0] exp_data [MAX_STORES];
    int          exp_count  = 0;
    int          store_idx  = 0;
    int          plen       = 0;
    int          errors     = 0;
    int          passed     = 0;
    logic [31:0] last_iaddr = '1;
    int          iwait      = 0;
    int          dwait      = 0;
    logic        dactive    = 1'b0;
    logic        dhit_store = 1'b0;
    string       names [NTESTS] = '{"alu_chain", "load_loop", "branches", "halt_order"};

    sc_datapath i_dut (
        .CLK       (CLK),
        .nrst      (nrst),
        .imemaddr  (imemaddr),
        .imemload  (imemload),
        .ihit      (ihit),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemload  (dmemload),
        .dhit      (dhit),
        .halt      (halt)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Instruction memory, new random wait whenever the PC moves
    task automatic imem_model();
        forever begin
            @(posedge CLK);
            #1;
            imemload = imem[imemaddr[9:2]];
            if (imemaddr != last_iaddr) begin
                last_iaddr = imemaddr;
                iwait      = $urandom_range(2, 0);
            end else if (iwait != 0) begin
                iwait = iwait - 1;
            end
            ihit = (iwait == 0);
        end
    endtask

    // Data memory, one access at a time, dhit high for one cycle
    task automatic dmem_model();
        forever begin
            @(posedge CLK);
            #1;
            if (!nrst || dhit) begin
                // Store finished at the edge just passed
                if (dhit && dhit_store) store_idx++;
                dhit    = 1'b0;
                dactive = 1'b0;
            end else if (dmemREN || dmemWEN) begin
                if (!dactive) begin
                    dactive = 1'b1;
                    dwait   = $urandom_range(4, 0);
                end
                if (dwait == 0) begin
                    dhit       = 1'b1;
                    dhit_store = dmemWEN;
                    if (dmemWEN) dmem[dmemaddr[9:2]] = dmemstore;
                    else dmemload = dmem[dmemaddr[9:2]];
                end else begin
                    dwait = dwait - 1;
                end
            end
        end
    endtask

    // Background data, every word distinct
    function automatic logic [31:0] fill_word(input int i);
        return 32'h5a5a_0000 ^ (i * 32'h0001_0003) ^ (i << 20);
    endfunction

    function automatic void clear_memories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = {OP_NOP, 28'h0};
            dmem[i] = fill_word(i);
        end
        plen = 0;
    endfunction

    // Append one instruction word to imem
    function automatic void emit(input opcode_t op, input int rd, input int rs1,
                                 input int rs2, input int imm);
        imem[plen] = {op, rd[3:0], rs1[3:0], rs2[3:0], imm[15:0]};
        plen++;
    endfunction

    task automatic build_program(input int id);
        int loop_top;
        case (id)
            0: begin
                // Back-to-back RAW chain through every ALU op
                emit(OP_ADDI, 1, 0, 0, 5);
                emit(OP_ADDI, 2, 1, 0, -3);
                emit(OP_ADD,  3, 1, 2, 0);
                emit(OP_SUB,  4, 2, 3, 0);
                emit(OP_SLT,  5, 4, 1, 0);
                emit(OP_SLT,  6, 1, 4, 0);
                emit(OP_XOR,  7, 3, 4, 0);
                emit(OP_AND,  8, 7, 3, 0);
                emit(OP_OR,   9, 8, 4, 0);
                emit(OP_SW,   0, 0, 3, 'h40);
                emit(OP_SW,   0, 0, 4, 'h44);
                emit(OP_SW,   0, 0, 5, 'h48);
                emit(OP_SW,   0, 0, 6, 'h4c);
                emit(OP_SW,   0, 0, 9, 'h50);
                emit(OP_HALT, 0, 0, 0, 0);
            end
            1: begin
                // Load loop, independent ADDI slips past a waiting load
                emit(OP_ADDI, 1, 0, 0, 'h80);
                emit(OP_ADDI, 11, 0, 0, 4);
                loop_top = plen;
                emit(OP_LW,   2, 1, 0, 0);
                emit(OP_ADDI, 5, 5, 0, 9);
                emit(OP_ADD,  3, 3, 2, 0);
                emit(OP_SW,   0, 1, 3, 'h40);
                emit(OP_ADDI, 1, 1, 0, 4);
                emit(OP_ADDI, 10, 10, 0, 1);
                emit(OP_BEQ,  0, 10, 11, 1);
                emit(OP_BEQ,  0, 0, 0, loop_top - plen - 1);
                emit(OP_LW,   6, 1, 0, 'h3c);
                emit(OP_SUB,  7, 6, 5, 0);
                emit(OP_SW,   0, 0, 7, 'h7c);
                emit(OP_SW,   0, 1, 5, -4);
                emit(OP_HALT, 0, 0, 0, 0);
            end
            2: begin
                // Taken, not-taken, then taken over two words
                emit(OP_ADDI, 1, 0, 0, 3);
                emit(OP_ADDI, 2, 0, 0, 3);
                emit(OP_ADDI, 3, 0, 0, 4);
                emit(OP_BEQ,  0, 1, 2, 1);
                emit(OP_SW,   0, 0, 1, 'h100);
                emit(OP_BEQ,  0, 1, 3, 1);
                emit(OP_SW,   0, 0, 3, 'h104);
                emit(OP_SW,   0, 0, 2, 'h108);
                emit(OP_BEQ,  0, 0, 0, 2);
                emit(OP_SW,   0, 0, 1, 'h10c);
                emit(OP_ADDI, 1, 0, 0, 77);
                emit(OP_SW,   0, 0, 1, 'h110);
                emit(OP_HALT, 0, 0, 0, 0);
            end
            default: begin
                // Stores still in flight when HALT reaches decode
                emit(OP_ADDI, 1, 0, 0, 'h55);
                emit(OP_LW,   2, 0, 0, 'h20);
                emit(OP_SW,   0, 0, 2, 'h200);
                emit(OP_SW,   0, 0, 1, 'h204);
                emit(OP_HALT, 0, 0, 0, 0);
                emit(OP_SW,   0, 0, 1, 'h208);
                emit(OP_ADDI, 1, 1, 0, 1);
                emit(OP_SW,   0, 0, 1, 'h20c);
            end
        endcase
    endtask

    // ISA reference, runs to HALT and records every store
    task automatic run_model();
        logic [31:0] r [`SC_NREGS];
        logic [31:0] m [256];
        instr_t      ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        int          pc;
        int          steps;
        bit          stopped;
        r         = '{default: '0};
        m         = dmem;
        pc        = 0;
        steps     = 0;
        stopped   = 1'b0;
        exp_count = 0;
        while (!stopped && steps < 1000) begin
            ins  = imem[pc];
            a    = r[ins.rs1];
            b    = r[ins.rs2];
            imm  = {{16{ins.imm[15]}}, ins.imm};
            addr = a + imm;
            pc++;
            steps++;
            case (ins.opcode)
                OP_ADD:  r[ins.rd] = a + b;
                OP_SUB:  r[ins.rd] = a - b;
                OP_AND:  r[ins.rd] = a & b;
                OP_OR:   r[ins.rd] = a | b;
                OP_XOR:  r[ins.rd] = a ^ b;
                OP_SLT:  r[ins.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                OP_ADDI: r[ins.rd] = a + imm;
                OP_LW:   r[ins.rd] = m[addr[9:2]];
                OP_SW: begin
                    m[addr[9:2]]        = b;
                    exp_addr[exp_count] = addr;
                    exp_data[exp_count] = b;
                    exp_count++;
                end
                // pc is a word index already past the branch
                OP_BEQ:  if (a == b) pc = pc + $signed(imm);
                OP_HALT: stopped = 1'b1;
                default: ;
            endcase
            r[0] = '0;
        end
    endtask

    task automatic run_test(input int id);
        int err_before;
        err_before = errors;
        @(posedge CLK);
        #1 nrst = 1'b0;
        clear_memories();
        build_program(id);
        run_model();
        store_idx = 0;
        repeat (2) @(posedge CLK);
        #1 nrst = 1'b1;
        while (!halt) @(posedge CLK);
        // Quiet period, catches stores after halt
        repeat (20) @(posedge CLK);
        if (errors == err_before) passed++;
        $display("Test %0d %s: %s, %0d of %0d stores", id, names[id],
                 (errors == err_before) ? "pass" : "fail", store_idx, exp_count);
    endtask

    initial begin
        int seed;
        seed     = 32'hc155;
        void'($urandom(seed));
        nrst     = 1'b0;
        ihit     = 1'b0;
        imemload = '0;
        dhit     = 1'b0;
        dmemload = '0;
        // Memory models, started after seeding
        fork
            imem_model();
            dmem_model();
        join_none
        for (int t = 0; t < NTESTS; t++) run_test(t);
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 NTESTS, passed, NTESTS - passed, errors);
        if (errors == 0 && passed == NTESTS) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, budget of 4000 cycles per test
    initial begin
        repeat (4000 * NTESTS) @(posedge CLK);
        $display("Watchdog expired after %0d cycles, the core never halted", 4000 * NTESTS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Reset state
    a_reset_quiet: assert property (@(posedge CLK) !nrst |-> !dmemREN && !dmemWEN && !halt)
        else begin
            errors++;
            $display("Time %0t: memory strobe or halt high during reset", $time);
        end

    a_reset_pc: assert property (@(posedge CLK) !nrst |-> imemaddr == `SC_RESET_PC)
        else begin
            errors++;
            $display("FAIL %0t imemaddr expected %h got %h", $time, `SC_RESET_PC, imemaddr);
        end

    a_strobe_excl: assert property (@(posedge CLK) disable iff (!nrst) !(dmemREN && dmemWEN))
        else begin
            errors++;
            $display("Time %0t: dmemREN and dmemWEN high together", $time);
        end

    // Each completed store against the next predicted one
    a_store_extra: assert property (@(posedge CLK) disable iff (!nrst)
        dmemWEN && dhit |-> store_idx < exp_count)
        else begin
            errors++;
            $display("Time %0t: unexpected store to %h", $time, dmemaddr);
        end

    a_store_addr: assert property (@(posedge CLK) disable iff (!nrst)
        dmemWEN && dhit && store_idx < exp_count |-> dmemaddr == exp_addr[store_idx])
        else begin
            errors++;
            $display("FAIL %0t dmemaddr expected %h got %h", $time, exp_addr[store_idx],
                     dmemaddr);
        end

    a_store_data: assert property (@(posedge CLK) disable iff (!nrst)
        dmemWEN && dhit && store_idx < exp_count |-> dmemstore == exp_data[store_idx])
        else begin
            errors++;
            $display("FAIL %0t dmemstore expected %h got %h", $time, exp_data[store_idx],
                     dmemstore);
        end

    // Halt only after all earlier stores, then sticky and silent
    a_halt_done: assert property (@(posedge CLK) disable iff (!nrst)
        halt |-> store_idx == exp_count)
        else begin
            errors++;
            $display("Time %0t: halt high with %0d of %0d stores done", $time, store_idx,
                     exp_count);
        end

    a_halt_quiet: assert property (@(posedge CLK) disable iff (!nrst)
        halt |-> !dmemREN && !dmemWEN)
        else begin
            errors++;
            $display("Time %0t: data memory access while halted", $time);
        end

    a_halt_sticky: assert property (@(posedge CLK) disable iff (!nrst) halt |=> halt)
        else begin
            errors++;
            $display("Time %0t: halt dropped before reset", $time);
        end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipeline_pkg.sv
hdl/fetch.sv
hdl/scoreboard.sv
hdl/regfile.sv
hdl/fu_alu.sv
hdl/fu_scalar_ls.sv
hdl/sc_datapath.sv
dv/sc_datapath_tb.sv
